//--- src/trace_pkg.sv
// ----------------------------
// commit-trace record types and defaults shared by the trace unit
// import with trace_pkg::* in the module header
// ----------------------------

package trace_pkg;

  // ----------------------------
  // configuration defaults
  // ----------------------------
  localparam int NR_PORTS_DEF   = 2;
  localparam int FIFO_DEPTH_DEF = 4;

  // ----------------------------
  // commit side types
  // ----------------------------
  typedef logic [31:0] pc_t;

  // bit 31 set means interrupt
  typedef logic [31:0] cause_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } priv_t;

  // wraps at 16 bits
  typedef logic [15:0] seq_t;

  // saturates at all ones
  typedef logic [15:0] drop_cnt_t;

  typedef logic [7:0] cause_lo_t;

  typedef enum logic [1:0] {
    KIND_RETIRE    = 2'd0,
    KIND_EXCEPTION = 2'd1,
    KIND_INTERRUPT = 2'd2
  } kind_e;

  // one queued trace entry, 60 bits
  typedef struct packed {
    pc_t       pc;
    seq_t      seq;
    kind_e     kind;
    priv_t     priv;
    cause_lo_t cause_lo;
  } trace_rec_t;

endpackage

//--- src/wb_pkg.sv
// ----------------------------
// Wishbone widths and the trace sink address map
// the info word layout is given as bit offsets
// ----------------------------

package wb_pkg;

  typedef logic [31:0] wb_adr_t;
  typedef logic [31:0] wb_dat_t;

  // ----------------------------
  // sink address map
  // ----------------------------
  localparam wb_adr_t TRACE_BASE_ADR = 32'h0000_1000;
  localparam wb_adr_t PC_WORD_OFS    = 32'h0000_0000;
  localparam wb_adr_t INFO_WORD_OFS  = 32'h0000_0004;

  // ----------------------------
  // info word layout
  // ----------------------------
  // seq in 15:0
  localparam int INFO_SEQ_LSB   = 0;
  // cause low byte in 23:16
  localparam int INFO_CAUSE_LSB = 16;
  // priv in 25:24
  localparam int INFO_PRIV_LSB  = 24;
  // kind in 27:26, bits above stay zero
  localparam int INFO_KIND_LSB  = 26;

endpackage

//--- src/trace_fifo_if.sv
// ----------------------------
// link between one trace FIFO, its writer and its reader
// one instance per commit port
// ----------------------------

`timescale 1ns/1ps

interface trace_fifo_if import trace_pkg::*; ();

  // write side, push only while full is low
  logic       push;
  trace_rec_t push_rec;
  logic       full;

  // read side, pop_rec valid while empty is low
  logic       pop;
  trace_rec_t pop_rec;
  logic       empty;

  modport writer (
    output push,
    output push_rec,
    input  full
  );

  modport reader (
    output pop,
    input  pop_rec,
    input  empty
  );

  modport buffer (
    input  push,
    input  push_rec,
    output full,
    input  pop,
    output pop_rec,
    output empty
  );

endinterface

//--- src/commit_classifier.sv
// ----------------------------
// classifies committed instructions into trace records
// stamps sequence numbers, pushes per-port FIFOs, counts drops
// ----------------------------

`timescale 1ns/1ps

module commit_classifier import trace_pkg::*; #(
  parameter int NR_PORTS = NR_PORTS_DEF
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic [NR_PORTS-1:0]   commit_ack_i,
  input  pc_t [NR_PORTS-1:0]    commit_pc_i,
  input  logic [NR_PORTS-1:0]   commit_ex_valid_i,
  input  cause_t [NR_PORTS-1:0] commit_cause_i,
  input  priv_t                 priv_lvl_i,
  trace_fifo_if.writer          fifo_wr [NR_PORTS],
  output drop_cnt_t             dropped_cnt_o
);

  seq_t                      seq_q;
  seq_t                      seq_next;
  drop_cnt_t                 drop_q;
  drop_cnt_t                 drop_next;
  logic [NR_PORTS-1:0]       full;
  logic [NR_PORTS-1:0]       push;
  trace_rec_t [NR_PORTS-1:0] rec;

  // interface arrays need constant indices
  for (genvar i = 0; i < NR_PORTS; i++) begin : gen_wr
    assign full[i]             = fifo_wr[i].full;
    assign fifo_wr[i].push     = push[i];
    assign fifo_wr[i].push_rec = rec[i];
  end

  // ----------------------------
  // classify and number
  // ----------------------------
  always_comb begin
    seq_t ofs;
    ofs = '0;
    for (int i = 0; i < NR_PORTS; i++) begin
      rec[i].pc       = commit_pc_i[i];
      rec[i].seq      = seq_q + ofs;
      rec[i].priv     = priv_lvl_i;
      rec[i].cause_lo = commit_cause_i[i][7:0];
      if (!commit_ex_valid_i[i]) begin
        rec[i].kind = KIND_RETIRE;
      end else if (commit_cause_i[i][31]) begin
        rec[i].kind = KIND_INTERRUPT;
      end else begin
        rec[i].kind = KIND_EXCEPTION;
      end
      // a dropped commit still takes its number
      if (commit_ack_i[i]) begin
        ofs = ofs + 1'b1;
      end
    end
    seq_next = seq_q + ofs;
  end

  assign push = commit_ack_i & ~full;

  // saturating drop count
  always_comb begin
    logic [$bits(drop_cnt_t):0] sum;
    sum = {1'b0, drop_q};
    for (int i = 0; i < NR_PORTS; i++) begin
      if (commit_ack_i[i] && full[i]) begin
        sum = sum + 1'b1;
      end
    end
    drop_next = sum[$bits(drop_cnt_t)] ? '1 : sum[$bits(drop_cnt_t)-1:0];
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      seq_q  <= '0;
      drop_q <= '0;
    end else begin
      seq_q  <= seq_next;
      drop_q <= drop_next;
    end
  end

  assign dropped_cnt_o = drop_q;

endmodule

//--- src/trace_fifo.sv
// ----------------------------
// circular buffer of trace records for one commit port
// push and pop may happen in the same cycle
// ----------------------------

`timescale 1ns/1ps

module trace_fifo import trace_pkg::*; #(
  parameter int DEPTH = FIFO_DEPTH_DEF
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  trace_fifo_if.buffer  q
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  trace_rec_t       mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  // pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign q.full    = (cnt_q == CNT_W'(DEPTH));
  assign q.empty   = (cnt_q == '0);
  assign q.pop_rec = mem[rd_ptr_q];

  assign do_push = q.push & ~q.full;
  assign do_pop  = q.pop & ~q.empty;

  // ----------------------------
  // storage
  // ----------------------------
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= q.push_rec;
    end
  end

  // ----------------------------
  // pointers and occupancy
  // ----------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

//--- src/trace_wb_master.sv
// ----------------------------
// drains the trace FIFOs round robin into the sink
// each record is a pc word then an info word, Wishbone classic writes
// ----------------------------

`timescale 1ns/1ps

module trace_wb_master import trace_pkg::*, wb_pkg::*; #(
  parameter int NR_PORTS = NR_PORTS_DEF
) (
  input  logic          clk_i,
  input  logic          arst_n_i,
  trace_fifo_if.reader  fifo_rd [NR_PORTS],
  output logic          wb_cyc_o,
  output logic          wb_stb_o,
  output logic          wb_we_o,
  output wb_adr_t       wb_adr_o,
  output wb_dat_t       wb_dat_o,
  input  logic          wb_ack_i
);

  localparam int PORT_W = (NR_PORTS > 1) ? $clog2(NR_PORTS) : 1;

  localparam wb_adr_t PC_ADR   = TRACE_BASE_ADR + PC_WORD_OFS;
  localparam wb_adr_t INFO_ADR = TRACE_BASE_ADR + INFO_WORD_OFS;

  typedef enum logic {
    WORD_PC,
    WORD_INFO
  } word_e;

  logic                      active_q;
  word_e                     word_q;
  logic [PORT_W-1:0]         grant_q;
  logic [PORT_W-1:0]         last_q;
  logic [NR_PORTS-1:0]       empty;
  trace_rec_t [NR_PORTS-1:0] head;
  trace_rec_t                cur;
  logic                      found;
  logic [PORT_W-1:0]         pick;
  logic                      pop_hit;
  wb_dat_t                   info;

  // record done at the info word's ack
  assign pop_hit = active_q & wb_ack_i & (word_q == WORD_INFO);

  for (genvar i = 0; i < NR_PORTS; i++) begin : gen_rd
    assign empty[i]      = fifo_rd[i].empty;
    assign head[i]       = fifo_rd[i].pop_rec;
    assign fifo_rd[i].pop = pop_hit & (grant_q == PORT_W'(i));
  end

  // ----------------------------
  // round-robin pick
  // ----------------------------
  // first non-empty port after the one served last
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    pick  = last_q;
    for (int k = 1; k <= NR_PORTS; k++) begin
      idx = (int'(last_q) + k) % NR_PORTS;
      if (!found && !empty[idx]) begin
        found = 1'b1;
        pick  = PORT_W'(idx);
      end
    end
  end

  // ----------------------------
  // write sequencer
  // ----------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      active_q <= 1'b0;
      word_q   <= WORD_PC;
      grant_q  <= '0;
      // so that port 0 wins first
      last_q   <= PORT_W'(NR_PORTS - 1);
    end else if (!active_q) begin
      if (found) begin
        active_q <= 1'b1;
        word_q   <= WORD_PC;
        grant_q  <= pick;
      end
    end else if (wb_ack_i) begin
      if (word_q == WORD_PC) begin
        word_q <= WORD_INFO;
      end else begin
        active_q <= 1'b0;
        last_q   <= grant_q;
      end
    end
  end

  // head of the granted FIFO holds until its pop
  assign cur = head[grant_q];

  always_comb begin
    info = '0;
    info[INFO_SEQ_LSB +: $bits(seq_t)]        = cur.seq;
    info[INFO_CAUSE_LSB +: $bits(cause_lo_t)] = cur.cause_lo;
    info[INFO_PRIV_LSB +: $bits(priv_t)]      = cur.priv;
    info[INFO_KIND_LSB +: $bits(kind_e)]      = cur.kind;
  end

  assign wb_cyc_o = active_q;
  assign wb_stb_o = active_q;
  assign wb_we_o  = active_q;
  assign wb_adr_o = (word_q == WORD_PC) ? PC_ADR : INFO_ADR;
  assign wb_dat_o = (word_q == WORD_PC) ? cur.pc : info;

endmodule

//--- src/trace_unit.sv
// ----------------------------
// retire-trace unit top level
// commit ports in, Wishbone classic writes to a trace sink out
// ----------------------------

`timescale 1ns/1ps

module trace_unit import trace_pkg::*, wb_pkg::*; #(
  parameter int NR_PORTS   = NR_PORTS_DEF,
  parameter int FIFO_DEPTH = FIFO_DEPTH_DEF
) (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // commit side
  input  logic [NR_PORTS-1:0]   commit_ack_i,
  input  pc_t [NR_PORTS-1:0]    commit_pc_i,
  input  logic [NR_PORTS-1:0]   commit_ex_valid_i,
  input  cause_t [NR_PORTS-1:0] commit_cause_i,
  input  priv_t                 priv_lvl_i,
  // trace sink
  output logic                  wb_cyc_o,
  output logic                  wb_stb_o,
  output logic                  wb_we_o,
  output wb_adr_t               wb_adr_o,
  output wb_dat_t               wb_dat_o,
  input  logic                  wb_ack_i,
  output drop_cnt_t             dropped_cnt_o
);

  trace_fifo_if fifo_q [NR_PORTS] ();

  // ----------------------------
  // producer
  // ----------------------------
  commit_classifier #(
    .NR_PORTS (NR_PORTS)
  ) commit_classifier_i (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .commit_ack_i      (commit_ack_i),
    .commit_pc_i       (commit_pc_i),
    .commit_ex_valid_i (commit_ex_valid_i),
    .commit_cause_i    (commit_cause_i),
    .priv_lvl_i        (priv_lvl_i),
    .fifo_wr           (fifo_q),
    .dropped_cnt_o     (dropped_cnt_o)
  );

  // one queue per commit port
  for (genvar i = 0; i < NR_PORTS; i++) begin : gen_fifo
    trace_fifo #(
      .DEPTH (FIFO_DEPTH)
    ) trace_fifo_i (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .q        (fifo_q[i])
    );
  end

  // ----------------------------
  // consumer
  // ----------------------------
  trace_wb_master #(
    .NR_PORTS (NR_PORTS)
  ) trace_wb_master_i (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .fifo_rd  (fifo_q),
    .wb_cyc_o (wb_cyc_o),
    .wb_stb_o (wb_stb_o),
    .wb_we_o  (wb_we_o),
    .wb_adr_o (wb_adr_o),
    .wb_dat_o (wb_dat_o),
    .wb_ack_i (wb_ack_i)
  );

endmodule

//--- verif/trace_unit_checker.sv
// ----------------------------
// Wishbone and drop-count assertions for the trace unit
// bound into trace_unit from the testbench
// ----------------------------

`timescale 1ns/1ps

module trace_unit_checker import trace_pkg::*, wb_pkg::*; (
  input logic      clk_i,
  input logic      arst_n_i,
  input logic      wb_cyc_o,
  input logic      wb_stb_o,
  input logic      wb_we_o,
  input wb_adr_t   wb_adr_o,
  input wb_dat_t   wb_dat_o,
  input logic      wb_ack_i,
  input drop_cnt_t dropped_cnt_o
);

  // read by the testbench at the end of the run
  int unsigned err_cnt = 0;

  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_o |-> wb_cyc_o)
    else begin
      err_cnt++;
      $error("wb_stb_o high without wb_cyc_o");
    end

  // the sink only ever sees writes
  stb_is_write: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    wb_stb_o |-> wb_we_o)
    else begin
      err_cnt++;
      $error("wb_stb_o high without wb_we_o");
    end

  // classic cycle holds address and data until ack
  held_until_ack: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (wb_stb_o && !wb_ack_i) |=> ($stable(wb_adr_o) && $stable(wb_dat_o)))
    else begin
      err_cnt++;
      $error("address or data changed while waiting for ack");
    end

  drops_never_fall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    dropped_cnt_o >= $past(dropped_cnt_o))
    else begin
      err_cnt++;
      $error("dropped_cnt_o decreased");
    end

endmodule

//--- verif/tb_trace_unit.sv
// ----------------------------
// directed tests for the retire-trace unit
// a Wishbone sink model collects records and compares them with a model
// ----------------------------

`timescale 1ns/1ps

module tb_trace_unit import trace_pkg::*, wb_pkg::*; ();

  localparam int      NR_PORTS   = 2;
  localparam int      FIFO_DEPTH = 4;
  localparam wb_adr_t PC_ADR     = TRACE_BASE_ADR + PC_WORD_OFS;
  localparam wb_adr_t INFO_ADR   = TRACE_BASE_ADR + INFO_WORD_OFS;

  logic                  clk_i;
  logic                  arst_n_i;
  logic [NR_PORTS-1:0]   commit_ack_i;
  pc_t [NR_PORTS-1:0]    commit_pc_i;
  logic [NR_PORTS-1:0]   commit_ex_valid_i;
  cause_t [NR_PORTS-1:0] commit_cause_i;
  priv_t                 priv_lvl_i;
  logic                  wb_cyc_o;
  logic                  wb_stb_o;
  logic                  wb_we_o;
  wb_adr_t               wb_adr_o;
  wb_dat_t               wb_dat_o;
  logic                  wb_ack_i;
  drop_cnt_t             dropped_cnt_o;

  // expected records per port, pc word in the upper half
  logic [63:0] exp_q [NR_PORTS][$];
  seq_t        seq_model  = '0;
  logic [31:0] stim_lfsr  = 32'h1358_49bb;
  logic [31:0] sink_lfsr  = 32'h1358_49bb;
  bit          hold_ack   = 1'b0;
  bit          ack_rand   = 1'b0;
  bit          have_pc    = 1'b0;
  wb_dat_t     rx_pc;
  int          wait_cnt   = 0;
  int          cur_delay  = 0;

  trace_unit #(
    .NR_PORTS   (NR_PORTS),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) trace_unit_i (
    .clk_i             (clk_i),
    .arst_n_i          (arst_n_i),
    .commit_ack_i      (commit_ack_i),
    .commit_pc_i       (commit_pc_i),
    .commit_ex_valid_i (commit_ex_valid_i),
    .commit_cause_i    (commit_cause_i),
    .priv_lvl_i        (priv_lvl_i),
    .wb_cyc_o          (wb_cyc_o),
    .wb_stb_o          (wb_stb_o),
    .wb_we_o           (wb_we_o),
    .wb_adr_o          (wb_adr_o),
    .wb_dat_o          (wb_dat_o),
    .wb_ack_i          (wb_ack_i),
    .dropped_cnt_o     (dropped_cnt_o)
  );

  bind trace_unit trace_unit_checker checker_i (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_o      (wb_dat_o),
    .wb_ack_i      (wb_ack_i),
    .dropped_cnt_o (dropped_cnt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // ----------------------------
  // helpers and compare tasks
  // ----------------------------
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input string name, input wb_dat_t got, input wb_dat_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t ns: %s got %08h expected %08h",
                              $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input drop_cnt_t got, input drop_cnt_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("MISMATCH at %0t ns: %s got %0d expected %0d",
                              $time, name, got, exp));
    end
  endtask

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val   = {val[30:0], state[0]};
      state = state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    end
    return val;
  endfunction

  // info word: kind 27:26, priv 25:24, cause byte 23:16, seq 15:0
  task automatic note_commit(input int port, input pc_t pc, input logic ex,
                             input cause_t cause, input priv_t priv, input bit kept);
    logic [1:0] kind;
    kind = !ex ? 2'd0 : (cause[31] ? 2'd2 : 2'd1);
    if (kept) begin
      exp_q[port].push_back({pc, 4'h0, kind, priv, cause[7:0], seq_model});
    end
    // dropped commits still use up a number
    seq_model++;
  endtask

  task automatic stage_commit(input int port, input pc_t pc, input logic ex,
                              input cause_t cause, input priv_t priv, input bit kept);
    commit_ack_i[port]      <= 1'b1;
    commit_pc_i[port]       <= pc;
    commit_ex_valid_i[port] <= ex;
    commit_cause_i[port]    <= cause;
    priv_lvl_i              <= priv;
    note_commit(port, pc, ex, cause, priv, kept);
  endtask

  task automatic clear_commits();
    commit_ack_i <= '0;
  endtask

  function automatic int pending();
    int n;
    n = 0;
    for (int p = 0; p < NR_PORTS; p++) begin
      n += exp_q[p].size();
    end
    return n;
  endfunction

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (pending() != 0 || wb_cyc_o) begin
      @(negedge clk_i);
      n++;
      if (n > max_cycles) begin
        stop_on_error("timeout while waiting for the expected records at the sink");
      end
    end
  endtask

  task automatic wait_strobe(input int max_cycles);
    int n;
    n = 0;
    while (!wb_stb_o) begin
      @(negedge clk_i);
      n++;
      if (n > max_cycles) begin
        stop_on_error("timeout while waiting for a Wishbone strobe");
      end
    end
  endtask

  // ----------------------------
  // Wishbone sink model
  // ----------------------------
  task automatic take_word(input wb_adr_t adr, input wb_dat_t dat);
    logic [63:0] exp;
    int          port;
    if (!have_pc) begin
      check_word("wb_adr_o", adr, PC_ADR);
      rx_pc   = dat;
      have_pc = 1'b1;
    end else begin
      check_word("wb_adr_o", adr, INFO_ADR);
      have_pc = 1'b0;
      port    = int'(rx_pc[31:28]);
      if (port >= NR_PORTS) begin
        stop_on_error("record pc does not belong to any commit port");
      end
      if (exp_q[port].size() == 0) begin
        stop_on_error("sink received a record that was not expected");
      end
      exp = exp_q[port].pop_front();
      check_word("wb_dat_o pc word", rx_pc, exp[63:32]);
      check_word("wb_dat_o info word", dat, exp[31:0]);
    end
  endtask

  initial begin
    wb_ack_i = 1'b0;
    forever begin
      @(posedge clk_i);
      if (wb_ack_i) begin
        wb_ack_i <= 1'b0;
        take_word(wb_adr_o, wb_dat_o);
        wait_cnt  = 0;
        cur_delay = ack_rand ? int'(lfsr_take(sink_lfsr, 1)) : 0;
      end else if (wb_stb_o && !hold_ack) begin
        if (wait_cnt >= cur_delay) begin
          wb_ack_i <= 1'b1;
        end else begin
          wait_cnt++;
        end
      end
    end
  end

  // ----------------------------
  // directed tests
  // ----------------------------
  task automatic single_retire();
    @(posedge clk_i);
    stage_commit(0, 32'h0000_0100, 1'b0, 32'h0, PRIV_M, 1'b1);
    @(posedge clk_i);
    clear_commits();
    wait_drained(100);
  endtask

  task automatic classify_kinds();
    @(posedge clk_i);
    stage_commit(0, 32'h0000_0200, 1'b1, 32'd2, PRIV_S, 1'b1);
    @(posedge clk_i);
    clear_commits();
    stage_commit(1, 32'h1000_0300, 1'b1, 32'h8000_0007, PRIV_U, 1'b1);
    @(posedge clk_i);
    clear_commits();
    wait_drained(100);
  endtask

  task automatic same_cycle_pair();
    @(posedge clk_i);
    stage_commit(0, 32'h0000_0400, 1'b0, 32'h0, PRIV_M, 1'b1);
    stage_commit(1, 32'h1000_0500, 1'b1, 32'd5, PRIV_M, 1'b1);
    @(posedge clk_i);
    clear_commits();
    wait_drained(100);
  endtask

  task automatic back_pressure();
    drop_cnt_t base;
    @(negedge clk_i);
    base = dropped_cnt_o;
    @(posedge clk_i);
    hold_ack <= 1'b1;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk_i);
      // the in-flight record still sits at the FIFO head
      stage_commit(1, pc_t'(32'h1000_4000 + i * 4), 1'b0, 32'h0, PRIV_M, i < FIFO_DEPTH);
    end
    @(posedge clk_i);
    clear_commits();
    wait_strobe(20);
    @(negedge clk_i);
    check_count("dropped_cnt_o", dropped_cnt_o, drop_cnt_t'(base + 10 - FIFO_DEPTH));
    @(posedge clk_i);
    hold_ack <= 1'b0;
    wait_drained(200);
    // next record shows the sequence gap
    @(posedge clk_i);
    stage_commit(1, 32'h1000_5000, 1'b0, 32'h0, PRIV_M, 1'b1);
    @(posedge clk_i);
    clear_commits();
    wait_drained(100);
  endtask

  task automatic random_stream();
    logic [31:0] r;
    logic [31:0] a;
    drop_cnt_t   base;
    priv_t       priv;
    int          gap;
    @(negedge clk_i);
    base = dropped_cnt_o;
    @(posedge clk_i);
    ack_rand <= 1'b1;
    for (int k = 0; k < 40; k++) begin
      gap = 8 + int'(lfsr_take(stim_lfsr, 3));
      repeat (gap) @(posedge clk_i);
      r    = lfsr_take(stim_lfsr, 13);
      a    = lfsr_take(stim_lfsr, 26);
      priv = (r[4:3] == 2'd2) ? PRIV_M : priv_t'(r[4:3]);
      stage_commit(int'(r[0]), {3'b000, r[0], a[25:0], 2'b00}, r[1],
                   {r[2], 23'h0, r[12:5]}, priv, 1'b1);
      @(posedge clk_i);
      clear_commits();
    end
    wait_drained(300);
    @(negedge clk_i);
    check_count("dropped_cnt_o", dropped_cnt_o, base);
  endtask

  initial begin
    arst_n_i          = 1'b0;
    commit_ack_i      = '0;
    commit_pc_i       = '0;
    commit_ex_valid_i = '0;
    commit_cause_i    = '0;
    priv_lvl_i        = PRIV_M;
    repeat (4) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    check_word("wb_cyc_o", wb_dat_t'(wb_cyc_o), '0);
    check_word("wb_stb_o", wb_dat_t'(wb_stb_o), '0);
    check_word("wb_we_o", wb_dat_t'(wb_we_o), '0);
    check_count("dropped_cnt_o", dropped_cnt_o, '0);
    single_retire();
    classify_kinds();
    same_cycle_pair();
    back_pressure();
    random_stream();
    repeat (4) @(posedge clk_i);
    if (trace_unit_i.checker_i.err_cnt == 0) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      stop_on_error("the bound protocol checker reported assertion failures");
    end
  end

endmodule

//--- project.f
src/trace_pkg.sv
src/wb_pkg.sv
src/trace_fifo_if.sv
src/commit_classifier.sv
src/trace_fifo.sv
src/trace_wb_master.sv
src/trace_unit.sv
verif/trace_unit_checker.sv
verif/tb_trace_unit.sv

//--- Makefile
# Verilator flow for the retire-trace unit

TOP := tb_trace_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

obj_dir/V$(TOP): project.f $(shell cat project.f)
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

# pass only when the pass line shows up in the output
sim: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf obj_dir
